// File: Makefile
TOP := tb_soc

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard design/*.sv design/*.svh sim/*.sv)
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: design/dbus.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module dbus (
    input  wire                     clk_bus,
    input  wire                     reset_i,
    input  wire soc_pkg::dbus_req_t master_req_i,
    output soc_pkg::word_t          master_rddata_o,
    output logic                    master_stall_o,
    output soc_pkg::slave_req_t     slave_req_o,
    output logic                    gpio_sel_o,
    output logic                    ticker_sel_o,
    output logic                    flash_sel_o,
    input  wire soc_pkg::word_t     gpio_rddata_i,
    input  wire soc_pkg::word_t     ticker_rddata_i,
    input  wire soc_pkg::word_t     flash_rddata_i,
    input  wire                     flash_stall_i
);

    soc_pkg::dbus_slave_e sel;
    logic                 flash_busy_q;
    logic                 mapped;

    // Flash stays selected through its completion cycle.
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            flash_busy_q <= 1'b0;
        end else begin
            flash_busy_q <= flash_stall_i;
        end
    end

    // ------------------------------
    // Region decode.
    always_comb begin
        if (flash_busy_q) begin
            sel = soc_pkg::SLV_FLASH;
        end else if (master_req_i.address[31:24] == `SOC_FLASH_SEG) begin
            sel = soc_pkg::SLV_FLASH;
        end else if (master_req_i.address[31:8] == `SOC_GPIO_PAGE) begin
            sel = soc_pkg::SLV_GPIO;
        end else if (master_req_i.address[31:8] == `SOC_TICKER_PAGE) begin
            sel = soc_pkg::SLV_TICKER;
        end else begin
            sel = soc_pkg::SLV_NONE;
        end
    end

    assign mapped       = (sel != soc_pkg::SLV_NONE);
    assign gpio_sel_o   = (sel == soc_pkg::SLV_GPIO);
    assign ticker_sel_o = (sel == soc_pkg::SLV_TICKER);
    assign flash_sel_o  = (sel == soc_pkg::SLV_FLASH);

    // ------------------------------
    // Shared slave request.
    always_comb begin
        slave_req_o.byteenable = master_req_i.byteenable;
        slave_req_o.wrdata     = master_req_i.wrdata;
        slave_req_o.read       = master_req_i.read && mapped;
        slave_req_o.write      = master_req_i.write && mapped;
        if (flash_sel_o) begin
            slave_req_o.address = master_req_i.address[23:0];
        end else begin
            slave_req_o.address = {16'h0, master_req_i.address[7:0]}; // Page offset.
        end
    end

    // Read data return.
    always_comb begin
        case (sel)
            soc_pkg::SLV_GPIO:   master_rddata_o = gpio_rddata_i;
            soc_pkg::SLV_TICKER: master_rddata_o = ticker_rddata_i;
            soc_pkg::SLV_FLASH:  master_rddata_o = flash_rddata_i;
            default:             master_rddata_o = '0; // Unmapped.
        endcase
    end

    // Only the flash can hold the master.
    assign master_stall_o = flash_stall_i;

endmodule

`default_nettype wire

// File: design/flash_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module flash_ctrl (
    input  wire                      clk_bus,
    input  wire                      reset_i,
    input  wire                      sel_i,
    input  wire soc_pkg::slave_req_t bus_req_i,
    output soc_pkg::word_t           bus_rddata_o,
    output logic                     bus_stall_o,
    output soc_pkg::flash_addr_t     flash_address_o,
    output logic                     flash_ce_n_o,
    output logic                     flash_oe_n_o,
    input  wire [15:0]               flash_data_i
);

    localparam int WAIT  = `SOC_FLASH_WAIT;
    localparam int CNT_W = $clog2(WAIT + 1);

    soc_pkg::flash_state_e state_q;
    logic [CNT_W-1:0]      wait_cnt_q;
    logic [20:0]           word_addr_q;
    logic [15:0]           low_q;
    logic [15:0]           high_q;
    logic                  start;
    logic                  wait_done;
    logic                  flash_active;

    assign start     = sel_i && bus_req_i.read; // Writes are dropped.
    assign wait_done = (wait_cnt_q == CNT_W'(WAIT));

    // ------------------------------
    // FSM. The first half gets one extra
    // cycle for chip enable setup.
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            state_q    <= soc_pkg::FL_IDLE;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                soc_pkg::FL_IDLE: begin
                    if (start) begin
                        state_q    <= soc_pkg::FL_LOW;
                        wait_cnt_q <= '0;
                    end
                end
                soc_pkg::FL_LOW: begin
                    if (wait_done) begin
                        state_q    <= soc_pkg::FL_HIGH;
                        wait_cnt_q <= CNT_W'(1);
                    end else begin
                        wait_cnt_q <= wait_cnt_q + CNT_W'(1);
                    end
                end
                soc_pkg::FL_HIGH: begin
                    if (wait_done) begin
                        state_q <= soc_pkg::FL_DONE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + CNT_W'(1);
                    end
                end
                soc_pkg::FL_DONE: begin
                    state_q <= soc_pkg::FL_IDLE;
                end
                default: begin
                    state_q <= soc_pkg::FL_IDLE;
                end
            endcase
        end
    end

    // Word address and captured halves.
    always_ff @(posedge clk_bus) begin
        if (state_q == soc_pkg::FL_IDLE && start) begin
            word_addr_q <= bus_req_i.address[22:2];
        end
        if (state_q == soc_pkg::FL_LOW && wait_done) begin
            low_q <= flash_data_i;
        end
        if (state_q == soc_pkg::FL_HIGH && wait_done) begin
            high_q <= flash_data_i;
        end
    end

    // ------------------------------
    assign flash_active    = (state_q == soc_pkg::FL_LOW) || (state_q == soc_pkg::FL_HIGH);
    assign flash_ce_n_o    = ~flash_active;
    assign flash_oe_n_o    = ~flash_active;
    assign flash_address_o = {word_addr_q, state_q == soc_pkg::FL_HIGH}; // Odd half in FL_HIGH.

    // Stall from the strobe cycle until the word is ready.
    assign bus_stall_o = (state_q == soc_pkg::FL_IDLE && start) || flash_active;

    assign bus_rddata_o = (state_q == soc_pkg::FL_DONE) ? {high_q, low_q} : '0;

endmodule

`default_nettype wire

// File: design/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module gpio_top (
    input  wire                      clk_bus,
    input  wire                      reset_i,
    input  wire                      sel_i,
    input  wire soc_pkg::slave_req_t bus_req_i,
    output soc_pkg::word_t           bus_rddata_o,
    output soc_pkg::word_t           gpio_o,
    input  wire soc_pkg::word_t      gpio_i
);

    soc_pkg::word_t out_q;
    soc_pkg::word_t in_meta_q;
    soc_pkg::word_t in_sync_q;
    logic [7:0]     offset;

    assign offset = bus_req_i.address[7:0];

    // ------------------------------
    // Output register, byte merge.
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (sel_i && bus_req_i.write && offset == `SOC_REG_GPIO_OUT) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_req_i.byteenable[i]) begin
                    out_q[8*i +: 8] <= bus_req_i.wrdata[8*i +: 8];
                end
            end
        end
    end

    // Two stage input synchronizer.
    always_ff @(posedge clk_bus) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        case (offset)
            `SOC_REG_GPIO_OUT: bus_rddata_o = out_q;
            `SOC_REG_GPIO_IN:  bus_rddata_o = in_sync_q;
            default:           bus_rddata_o = '0;
        endcase
    end

    assign gpio_o = out_q;

endmodule

`default_nettype wire

// File: design/soc_dbus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_dbus_top (
    input  wire                     clk_bus,
    input  wire                     reset_i,
    input  wire soc_pkg::dbus_req_t master_req_i,
    output soc_pkg::word_t          master_rddata_o,
    output logic                    stall_o,
    output logic                    irq_o,
    output soc_pkg::word_t          gpio_o,
    input  wire soc_pkg::word_t     gpio_i,
    output soc_pkg::flash_addr_t    flash_address_o,
    output logic                    flash_ce_n_o,
    output logic                    flash_oe_n_o,
    input  wire [15:0]              flash_data_i
);

    wire soc_pkg::slave_req_t slave_req;
    wire soc_pkg::word_t      gpio_rddata;
    wire soc_pkg::word_t      ticker_rddata;
    wire soc_pkg::word_t      flash_rddata;
    wire                      gpio_sel;
    wire                      ticker_sel;
    wire                      flash_sel;
    wire                      flash_stall;

    // ------------------------------
    dbus dbus0 (
        .clk_bus         (clk_bus),
        .reset_i         (reset_i),
        .master_req_i    (master_req_i),
        .master_rddata_o (master_rddata_o),
        .master_stall_o  (stall_o),
        .slave_req_o     (slave_req),
        .gpio_sel_o      (gpio_sel),
        .ticker_sel_o    (ticker_sel),
        .flash_sel_o     (flash_sel),
        .gpio_rddata_i   (gpio_rddata),
        .ticker_rddata_i (ticker_rddata),
        .flash_rddata_i  (flash_rddata),
        .flash_stall_i   (flash_stall)
    );

    flash_ctrl flash0 (
        .clk_bus         (clk_bus),
        .reset_i         (reset_i),
        .sel_i           (flash_sel),
        .bus_req_i       (slave_req),
        .bus_rddata_o    (flash_rddata),
        .bus_stall_o     (flash_stall),
        .flash_address_o (flash_address_o),
        .flash_ce_n_o    (flash_ce_n_o),
        .flash_oe_n_o    (flash_oe_n_o),
        .flash_data_i    (flash_data_i)
    );

    ticker ticker0 (
        .clk_bus      (clk_bus),
        .reset_i      (reset_i),
        .sel_i        (ticker_sel),
        .bus_req_i    (slave_req),
        .bus_rddata_o (ticker_rddata),
        .irq_o        (irq_o)
    );

    gpio_top gpio0 (
        .clk_bus      (clk_bus),
        .reset_i      (reset_i),
        .sel_i        (gpio_sel),
        .bus_req_i    (slave_req),
        .bus_rddata_o (gpio_rddata),
        .gpio_o       (gpio_o),
        .gpio_i       (gpio_i)
    );

endmodule

`default_nettype wire

// File: design/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ------------------------------
// Address map.
`define SOC_FLASH_SEG            8'h1e      // Bits 31:24.
`define SOC_GPIO_PAGE            24'h1fd0f0 // Bits 31:8.
`define SOC_TICKER_PAGE          24'h1fd0e0 // Bits 31:8.

// Wait cycles per flash halfword, at least 1.
`define SOC_FLASH_WAIT           2

// ------------------------------
// Register offsets within a page.
`define SOC_REG_GPIO_OUT         8'h00
`define SOC_REG_GPIO_IN          8'h04
`define SOC_REG_TICKER_COUNT     8'h00
`define SOC_REG_TICKER_COMPARE   8'h04
`define SOC_REG_TICKER_IRQ_CLEAR 8'h08

`endif

// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [31:0] word_t;

    // Halfword address on the flash pins.
    typedef logic [21:0] flash_addr_t;

    // ------------------------------
    // Request from the bus master.
    typedef struct packed {
        logic [31:0] address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        word_t       wrdata;
    } dbus_req_t;

    // Request as seen by a slave, local offset only.
    typedef struct packed {
        logic [23:0] address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        word_t       wrdata;
    } slave_req_t;

    // ------------------------------
    typedef enum logic [1:0] {
        SLV_NONE,
        SLV_GPIO,
        SLV_TICKER,
        SLV_FLASH
    } dbus_slave_e;

    typedef enum logic [1:0] {
        FL_IDLE,
        FL_LOW,   // Even halfword.
        FL_HIGH,  // Odd halfword.
        FL_DONE
    } flash_state_e;

endpackage

`default_nettype wire

// File: design/ticker.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module ticker (
    input  wire                      clk_bus,
    input  wire                      reset_i,
    input  wire                      sel_i,
    input  wire soc_pkg::slave_req_t bus_req_i,
    output soc_pkg::word_t           bus_rddata_o,
    output logic                     irq_o
);

    soc_pkg::word_t count_q;
    soc_pkg::word_t compare_q;
    logic           irq_q;
    logic [7:0]     offset;
    logic           wr;

    assign offset = bus_req_i.address[7:0];
    assign wr     = sel_i && bus_req_i.write;

    // ------------------------------
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '1; // Far from the count.
            irq_q     <= 1'b0;
        end else begin
            if (wr && offset == `SOC_REG_TICKER_COUNT) begin
                count_q <= bus_req_i.wrdata;
            end else begin
                count_q <= count_q + 32'd1;
            end
            if (wr && offset == `SOC_REG_TICKER_COMPARE) begin
                compare_q <= bus_req_i.wrdata;
            end
            // Sticky until cleared.
            if (wr && offset == `SOC_REG_TICKER_IRQ_CLEAR) begin
                irq_q <= 1'b0;
            end else if (count_q == compare_q) begin
                irq_q <= 1'b1;
            end
        end
    end

    // Register read.
    always_comb begin
        case (offset)
            `SOC_REG_TICKER_COUNT:     bus_rddata_o = count_q;
            `SOC_REG_TICKER_COMPARE:   bus_rddata_o = compare_q;
            `SOC_REG_TICKER_IRQ_CLEAR: bus_rddata_o = {31'h0, irq_q};
            default:                   bus_rddata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/soc_pkg.sv
design/dbus.sv
design/flash_ctrl.sv
design/ticker.sv
design/gpio_top.sv
design/soc_dbus_top.sv
sim/soc_assert.sv
sim/tb_soc.sv

// File: sim/soc_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module soc_assert (
    input wire                     clk_bus,
    input wire                     reset_i,
    input wire soc_pkg::dbus_req_t req_i,
    input wire                     flash_sel_i,
    input wire                     stall_i,
    input wire                     irq_i,
    input wire                     flash_ce_n_i,
    input wire                     flash_oe_n_i
);

    localparam int STALL_MAX = 2 * `SOC_FLASH_WAIT + 2;

    int stall_run_q;

    // Stall cycles so far in this access.
    always_ff @(posedge clk_bus) begin
        if (reset_i || !stall_i) begin
            stall_run_q <= 0;
        end else begin
            stall_run_q <= stall_run_q + 1;
        end
    end

    // ------------------------------
    stall_only_on_flash_read: assert property (
        @(posedge clk_bus) disable iff (reset_i)
        stall_i |-> (flash_sel_i && req_i.read)
    ) else $error("stall without a selected flash read");

    stall_bounded: assert property (
        @(posedge clk_bus) disable iff (reset_i)
        stall_i |-> (stall_run_q < STALL_MAX)
    ) else $error("stall longer than one flash word");

    // The strobe cycle still counts as idle.
    strobes_high_in_idle: assert property (
        @(posedge clk_bus) disable iff (reset_i)
        (!stall_i || $rose(stall_i)) |-> (flash_ce_n_i && flash_oe_n_i)
    ) else $error("flash strobe low outside an access");

    irq_low_in_reset: assert property (
        @(posedge clk_bus) reset_i |=> !irq_i
    ) else $error("irq high after reset");

endmodule

bind soc_dbus_top soc_assert assert0 (
    .clk_bus      (clk_bus),
    .reset_i      (reset_i),
    .req_i        (master_req_i),
    .flash_sel_i  (flash_sel),
    .stall_i      (stall_o),
    .irq_i        (irq_o),
    .flash_ce_n_i (flash_ce_n_o),
    .flash_oe_n_i (flash_oe_n_o)
);

`default_nettype wire

// File: sim/soc_stim.txt
# op address arg value, all hex. W: arg is byte enables, value is write data.
# R/F/C read, value is expected. G: gpio_o. I: random gpio_i. Q: wait irq. K: irq now.
K 00000000 0 0
W 1fd0f000 f 11223344
G 00000000 0 11223344
W 1fd0f000 5 aabbccdd
G 00000000 0 11bb33dd
W 1fd0f000 a 99887766
G 00000000 0 99bb77dd
R 1fd0f000 f 99bb77dd
W 1fd0f000 0 ffffffff
G 00000000 0 99bb77dd
W 1fd0f000 8 5a000000
R 1fd0f000 f 5abb77dd
I 1fd0f004 f 0
I 1fd0f004 f 0
F 1e000000 f a5c2a5c3
F 1e000004 f a5c0a5c1
F 1e01234c f 34643465
F 1e7ffffc f 5a3c5a3d
R 20000000 f 0
W 1e000004 f deadbeef
F 1e000004 f a5c0a5c1
W 1fd0e000 f 00abc000
C 1fd0e000 f 00abc000
W 1fd0e000 f 0
W 1fd0e004 f 40
Q 00000000 0 1
R 1fd0e008 f 1
W 1fd0e008 f 0
K 00000000 0 0
R 1fd0e008 f 0

// File: sim/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc;

    localparam int FLASH_STALL = 2 * `SOC_FLASH_WAIT + 2;

    logic                 clk_bus;
    logic                 reset;
    soc_pkg::dbus_req_t   master_req;
    soc_pkg::word_t       master_rddata;
    logic                 stall;
    logic                 irq;
    soc_pkg::word_t       gpio_out;
    soc_pkg::word_t       gpio_in;
    soc_pkg::flash_addr_t flash_address;
    logic                 flash_ce_n;
    logic                 flash_oe_n;
    logic [15:0]          flash_data;

    logic [7:0]           op_q[$];
    logic [31:0]          addr_q[$];
    logic [31:0]          arg_q[$];
    logic [31:0]          value_q[$];

    int                   cycle_count;
    int                   cycle_limit;
    logic [31:0]          rnd_state;
    logic                 even_seen;
    logic                 odd_seen;

    soc_dbus_top dut0 (
        .clk_bus         (clk_bus),
        .reset_i         (reset),
        .master_req_i    (master_req),
        .master_rddata_o (master_rddata),
        .stall_o         (stall),
        .irq_o           (irq),
        .gpio_o          (gpio_out),
        .gpio_i          (gpio_in),
        .flash_address_o (flash_address),
        .flash_ce_n_o    (flash_ce_n),
        .flash_oe_n_o    (flash_oe_n),
        .flash_data_i    (flash_data)
    );

    // Flash chip, valid only with both strobes low.
    assign flash_data = (!flash_ce_n && !flash_oe_n) ? (flash_address[15:0] ^ 16'ha5c3) : 'x;

    always #5 clk_bus = ~clk_bus;

    always @(posedge clk_bus) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ------------------------------
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input soc_pkg::word_t actual,
                              input soc_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_word_range(input string name, input soc_pkg::word_t actual,
                                    input soc_pkg::word_t low, input soc_pkg::word_t high);
        if (actual < low || actual >= high) begin
            $display("ERROR %s: got %h, expected %h up to below %h", name, actual, low, high);
            abort_run();
        end
    endtask

    task automatic check_gpio(input soc_pkg::word_t actual, input soc_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR gpio_o: got %h, expected %h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flash_addr(input soc_pkg::flash_addr_t actual,
                                    input soc_pkg::flash_addr_t expected);
        if (actual !== expected) begin
            $display("ERROR flash_address_o: got %h, expected %h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_stall_cycles(input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR stall_o cycles: got %h, expected %h", actual, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic soc_pkg::dbus_req_t make_request(input logic [31:0] address,
            input logic [3:0] be, input logic wr, input soc_pkg::word_t data);
        soc_pkg::dbus_req_t req;
        req            = '0;
        req.address    = address;
        req.byteenable = be;
        req.read       = ~wr;
        req.write      = wr;
        req.wrdata     = data;
        return req;
    endfunction

    // ------------------------------
    // One access, held until stall drops.
    task automatic bus_access(input soc_pkg::dbus_req_t req, output soc_pkg::word_t rddata,
                              output int stalls);
        soc_pkg::flash_addr_t expected_addr;
        stalls    = 0;
        even_seen = 1'b0;
        odd_seen  = 1'b0;
        @(posedge clk_bus);
        master_req <= req;
        @(negedge clk_bus);
        while (stall) begin
            if (!flash_ce_n && !flash_oe_n) begin
                if (flash_address[0]) begin
                    odd_seen = 1'b1;
                end else begin
                    even_seen = 1'b1;
                end
                expected_addr = {req.address[22:2], odd_seen}; // No even half after odd.
                check_flash_addr(flash_address, expected_addr);
            end
            stalls = stalls + 1;
            @(negedge clk_bus);
        end
        rddata = master_rddata;
        @(posedge clk_bus);
        master_req <= '0;
    endtask

    task automatic run_operation(input logic [7:0] op, input logic [31:0] addr,
                                 input logic [31:0] arg, input logic [31:0] value);
        soc_pkg::word_t rd;
        int             stalls;
        case (op)
            "W": begin
                bus_access(make_request(addr, arg[3:0], 1'b1, value), rd, stalls);
                check_stall_cycles(stalls, 0);
            end
            "R": begin
                bus_access(make_request(addr, arg[3:0], 1'b0, '0), rd, stalls);
                check_stall_cycles(stalls, 0);
                check_word("master_rddata_o", rd, value);
            end
            "F": begin
                bus_access(make_request(addr, arg[3:0], 1'b0, '0), rd, stalls);
                check_stall_cycles(stalls, FLASH_STALL);
                if (!even_seen || !odd_seen) begin
                    $display("Flash read at %h did not drive both halfwords", addr);
                    abort_run();
                end
                check_word("master_rddata_o", rd, value);
            end
            "G": begin
                @(negedge clk_bus);
                check_gpio(gpio_out, value);
            end
            "I": begin
                rnd_state = xorshift32(rnd_state);
                @(posedge clk_bus);
                gpio_in <= rnd_state;
                repeat (3) @(posedge clk_bus); // Through the synchronizer.
                bus_access(make_request(addr, arg[3:0], 1'b0, '0), rd, stalls);
                check_word("master_rddata_o", rd, rnd_state);
            end
            "C": begin
                bus_access(make_request(addr, arg[3:0], 1'b0, '0), rd, stalls);
                check_word_range("master_rddata_o", rd, value, value + 32'(cycle_limit));
            end
            "Q": begin
                @(negedge clk_bus);
                while (irq !== value[0]) begin
                    @(negedge clk_bus);
                end
            end
            "K": begin
                @(negedge clk_bus);
                check_level("irq_o", irq, value[0]);
            end
            default: begin
                $display("Unknown operation %c in the stimulus file", op);
                abort_run();
            end
        endcase
    endtask

    // ------------------------------
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] arg;
        logic [31:0] value;

        clk_bus     = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        rnd_state   = 32'h7f13;
        even_seen   = 1'b0;
        odd_seen    = 1'b0;
        reset      <= 1'b1;
        master_req <= '0;
        gpio_in    <= '0;

        fd = $fopen("sim/soc_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/soc_stim.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, addr, arg, value);
                if (n != 4) begin
                    $display("Stimulus line could not be read: %s", line);
                    abort_run();
                end
                op_q.push_back(op);
                addr_q.push_back(addr);
                arg_q.push_back(arg);
                value_q.push_back(value);
            end
        end
        $fclose(fd);
        cycle_limit = op_q.size() * (2 * `SOC_FLASH_WAIT + 8) + 200; // Slack for irq waits.

        repeat (2) @(posedge clk_bus);
        reset <= 1'b0;

        foreach (op_q[i]) begin
            run_operation(op_q[i], addr_q[i], arg_q[i], value_q[i]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
